//--- verilog/matmul_cfg_pkg.sv
package matmul_cfg_pkg;

  // Width of one element of A or B
  localparam int DATA_W = 8;

  // Holds the sum of up to 16 products of two 8-bit operands without overflow
  localparam int ACC_W = 20;

  // Unsigned operand element
  typedef logic [DATA_W-1:0] data_t;

  // Accumulator and result element, C keeps the full width
  typedef logic [ACC_W-1:0] acc_t;

endpackage

//--- verilog/matmul_ctrl_pkg.sv
package matmul_ctrl_pkg;

  // Sequence of one operation, IDLE is the only state that accepts start
  typedef enum logic [1:0] {
    IDLE,
    LOAD,
    COMPUTE,
    DRAIN
  } ctrl_state_t;

  // Phase timer width, covers the longest phase for every supported N
  localparam int TIMER_W = 8;

  // One column of A and one row of B per cycle
  function automatic int load_cycles(input int n);
    return n;
  endfunction

  // Skew plus forwarding latency until the far corner cell has its last product
  function automatic int compute_cycles(input int n);
    return 2 * n - 2;
  endfunction

  // One row of C per cycle
  function automatic int drain_cycles(input int n);
    return n;
  endfunction

endpackage

//--- verilog/matmul_ctrl_if.sv
`timescale 1ns/1ns

interface matmul_ctrl_if #(
  parameter int N = 4
);

  logic load;
  logic acc_clear;
  logic capture;
  logic shift;

  // The array, the skew lines and the phase lengths are only sized for this range
  if (N < 2 || N > 16) begin : g_size_check
    $error("matmul_ctrl_if: N must be between 2 and 16");
  end

  modport ctrl (output load, acc_clear, capture, shift);
  modport skew (input load);
  modport array (input acc_clear);
  modport drain (input capture, shift);

endinterface

//--- verilog/matmul_ctrl.sv
`timescale 1ns/1ns

module matmul_ctrl #(
  parameter int N = 4
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                start,
  input  logic                                timer_last,
  output logic                                timer_load,
  output logic [matmul_ctrl_pkg::TIMER_W-1:0] timer_value,
  matmul_ctrl_if.ctrl                         ctrl,
  output logic                                in_progress,
  output logic                                c_valid,
  output logic                                done
);

  import matmul_ctrl_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        start_q;
  logic        start_pulse;
  // High in the first cycle after every state change
  logic        phase_first;

  ////////////////////////////////////////////////////////////////////////////
  // Start edge and next state
  ////////////////////////////////////////////////////////////////////////////

  assign start_pulse = start & ~start_q;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (start_pulse) begin
          state_next = LOAD;
        end
      end
      LOAD: begin
        if (timer_last) begin
          state_next = COMPUTE;
        end
      end
      COMPUTE: begin
        if (timer_last) begin
          state_next = DRAIN;
        end
      end
      DRAIN: begin
        if (timer_last) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  // Length of the phase that is entered when the current one ends
  always_comb begin
    case (state)
      IDLE:    timer_value = TIMER_W'(load_cycles(N));
      LOAD:    timer_value = TIMER_W'(compute_cycles(N));
      COMPUTE: timer_value = TIMER_W'(drain_cycles(N));
      default: timer_value = '0;
    endcase
  end

  assign timer_load = (state_next != state);

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= IDLE;
      start_q     <= 1'b0;
      phase_first <= 1'b0;
      done        <= 1'b0;
    end else begin
      state       <= state_next;
      start_q     <= start;
      phase_first <= timer_load;
      // done lands in the first IDLE cycle
      done        <= (state == DRAIN) && timer_last;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Strobes and status
  ////////////////////////////////////////////////////////////////////////////

  assign ctrl.load      = (state == LOAD);
  assign ctrl.acc_clear = (state == LOAD) && phase_first;
  assign ctrl.capture   = (state == DRAIN) && phase_first;
  assign ctrl.shift     = (state == DRAIN) && !phase_first;

  assign in_progress = (state == LOAD) || (state == COMPUTE);
  assign c_valid     = (state == DRAIN);

endmodule

//--- verilog/phase_timer.sv
`timescale 1ns/1ns

module phase_timer #(
  parameter int N = 4
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                load_en,
  input  logic [matmul_ctrl_pkg::TIMER_W-1:0] load_value,
  output logic                                last
);

  import matmul_ctrl_pkg::*;

  logic [TIMER_W-1:0] count;

  // COMPUTE is the longest phase for N of 2 and up
  if (compute_cycles(N) >= 2 ** TIMER_W) begin : g_width_check
    $error("phase_timer: TIMER_W too narrow for N");
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load_en) begin
      count <= load_value;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // A phase loaded with L cycles ends when one cycle is left
  assign last = (count == TIMER_W'(1));

endmodule

//--- verilog/operand_skew.sv
`timescale 1ns/1ns

module operand_skew #(
  parameter int N = 4
) (
  input  logic                          clk,
  input  logic                          reset,
  matmul_ctrl_if.skew                   ctrl,
  input  matmul_cfg_pkg::data_t [N-1:0] a_data,
  input  matmul_cfg_pkg::data_t [N-1:0] b_data,
  output matmul_cfg_pkg::data_t [N-1:0] a_lanes,
  output matmul_cfg_pkg::data_t [N-1:0] b_lanes
);

  import matmul_cfg_pkg::*;

  data_t [N-1:0] a_in;
  data_t [N-1:0] b_in;

  // Outside LOAD only zeros enter, which flushes the grid between operations
  assign a_in = ctrl.load ? a_data : '0;
  assign b_in = ctrl.load ? b_data : '0;

  for (genvar i = 0; i < N; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign a_lanes[0] = a_in[0];
      assign b_lanes[0] = b_in[0];
    end else begin : g_delay
      // Lane i is a shift line i registers deep
      data_t [i-1:0] a_dly;
      data_t [i-1:0] b_dly;

      always_ff @(posedge clk) begin
        if (reset) begin
          a_dly <= '0;
          b_dly <= '0;
        end else begin
          a_dly[0] <= a_in[i];
          b_dly[0] <= b_in[i];
          for (int k = 1; k < i; k++) begin
            a_dly[k] <= a_dly[k-1];
            b_dly[k] <= b_dly[k-1];
          end
        end
      end

      assign a_lanes[i] = a_dly[i-1];
      assign b_lanes[i] = b_dly[i-1];
    end
  end

endmodule

//--- verilog/pe_array.sv
`timescale 1ns/1ns

module pe_array #(
  parameter int N = 4
) (
  input  logic                                clk,
  input  logic                                reset,
  matmul_ctrl_if.array                        ctrl,
  input  matmul_cfg_pkg::data_t [N-1:0]       a_lanes,
  input  matmul_cfg_pkg::data_t [N-1:0]       b_lanes,
  output matmul_cfg_pkg::acc_t  [N-1:0][N-1:0] acc
);

  import matmul_cfg_pkg::*;

  // Forwarding registers, a moves right along a row and b moves down a column
  data_t a_fwd [N][N];
  data_t b_fwd [N][N];

  ////////////////////////////////////////////////////////////////////////////
  // Cell grid
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < N; i++) begin : g_row
    for (genvar j = 0; j < N; j++) begin : g_col
      data_t a_op;
      data_t b_op;
      acc_t  prod;

      // Edge cells take the skewed lanes, inner cells their neighbour's register
      if (j == 0) begin : g_a_edge
        assign a_op = a_lanes[i];
      end else begin : g_a_inner
        assign a_op = a_fwd[i][j-1];
      end

      if (i == 0) begin : g_b_edge
        assign b_op = b_lanes[j];
      end else begin : g_b_inner
        assign b_op = b_fwd[i-1][j];
      end

      assign prod = acc_t'(a_op) * acc_t'(b_op);

      always_ff @(posedge clk) begin
        if (reset) begin
          a_fwd[i][j] <= '0;
          b_fwd[i][j] <= '0;
          acc[i][j]   <= '0;
        end else begin
          a_fwd[i][j] <= a_op;
          b_fwd[i][j] <= b_op;
          // Operands are still zero here for every cell except (0,0)
          acc[i][j]   <= ctrl.acc_clear ? prod : acc[i][j] + prod;
        end
      end
    end
  end

endmodule

//--- verilog/result_drain.sv
`timescale 1ns/1ns

module result_drain #(
  parameter int N = 4
) (
  input  logic                                clk,
  input  logic                                reset,
  matmul_ctrl_if.drain                        ctrl,
  input  matmul_cfg_pkg::acc_t [N-1:0][N-1:0] acc,
  output matmul_cfg_pkg::acc_t [N-1:0]        c_data
);

  import matmul_cfg_pkg::*;

  // Rows 1 to N-1 wait here, row 0 goes straight out on the capture cycle
  acc_t [N-1:0] bank [N-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int r = 0; r < N - 1; r++) begin
        bank[r] <= '0;
      end
    end else if (ctrl.capture) begin
      for (int r = 0; r < N - 1; r++) begin
        bank[r] <= acc[r+1];
      end
    end else if (ctrl.shift) begin
      for (int r = 0; r < N - 2; r++) begin
        bank[r] <= bank[r+1];
      end
      bank[N-2] <= '0;
    end
  end

  assign c_data = ctrl.capture ? acc[0] : bank[0];

endmodule

//--- verilog/matmul_top.sv
`timescale 1ns/1ns

module matmul_top #(
  parameter int N = 4
) (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             start,
  input  matmul_cfg_pkg::data_t [N-1:0]    a_data,
  input  matmul_cfg_pkg::data_t [N-1:0]    b_data,
  output logic                             in_progress,
  output logic                             c_valid,
  output matmul_cfg_pkg::acc_t  [N-1:0]    c_data,
  output logic                             done
);

  import matmul_cfg_pkg::*;
  import matmul_ctrl_pkg::*;

  logic               timer_load;
  logic               timer_last;
  logic [TIMER_W-1:0] timer_value;

  // Skewed operand lanes into the grid
  data_t [N-1:0] a_lanes;
  data_t [N-1:0] b_lanes;

  // Accumulators, acc[i][j] is element (i,j) of C
  acc_t [N-1:0][N-1:0] acc;

  matmul_ctrl_if #(.N(N)) ctrl_bus ();

  ////////////////////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////////////////////

  matmul_ctrl #(.N(N)) u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .timer_last  (timer_last),
    .timer_load  (timer_load),
    .timer_value (timer_value),
    .ctrl        (ctrl_bus.ctrl),
    .in_progress (in_progress),
    .c_valid     (c_valid),
    .done        (done)
  );

  phase_timer #(.N(N)) u_timer (
    .clk        (clk),
    .reset      (reset),
    .load_en    (timer_load),
    .load_value (timer_value),
    .last       (timer_last)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Data path
  ////////////////////////////////////////////////////////////////////////////

  operand_skew #(.N(N)) u_skew (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (ctrl_bus.skew),
    .a_data  (a_data),
    .b_data  (b_data),
    .a_lanes (a_lanes),
    .b_lanes (b_lanes)
  );

  pe_array #(.N(N)) u_array (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (ctrl_bus.array),
    .a_lanes (a_lanes),
    .b_lanes (b_lanes),
    .acc     (acc)
  );

  result_drain #(.N(N)) u_drain (
    .clk    (clk),
    .reset  (reset),
    .ctrl   (ctrl_bus.drain),
    .acc    (acc),
    .c_data (c_data)
  );

endmodule

//--- verif/matmul_asserts.sv
`timescale 1ns/1ns

module matmul_asserts #(
  parameter int N = 4
) (
  input logic clk,
  input logic reset,
  input logic in_progress,
  input logic c_valid,
  input logic done
);

  // Number of c_valid cycles already seen in the current drain
  int valid_run;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_run <= 0;
    end else if (c_valid) begin
      valid_run <= valid_run + 1;
    end else begin
      valid_run <= 0;
    end
  end

  a_done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else $error("done stayed high for more than one cycle");

  a_valid_run: assert property (@(posedge clk) disable iff (reset)
    (c_valid && valid_run < N - 1) |=> c_valid)
    else $error("c_valid fell before N rows were shifted out");

  // The last row is followed directly by done
  a_valid_end: assert property (@(posedge clk) disable iff (reset)
    (c_valid && valid_run == N - 1) |=> (!c_valid && done))
    else $error("c_valid did not end after N cycles with done");

  a_no_overlap: assert property (@(posedge clk) disable iff (reset) !(in_progress && c_valid))
    else $error("in_progress and c_valid were high together");

endmodule

//--- verif/tb_matmul.sv
`timescale 1ns/1ns

module tb_matmul;

  import matmul_cfg_pkg::*;

  localparam int N = 4;
  localparam int NUM_TESTS = 7;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * (4 * N + 8) + 20;

  typedef data_t [N-1:0][N-1:0] data_mat_t;
  typedef acc_t  [N-1:0][N-1:0] acc_mat_t;
  typedef enum logic {KIND_FIXED, KIND_RANDOM} kind_t;

  // Operands of one operation, whether start stays high and the expected product
  typedef struct packed {
    kind_t     kind;
    logic      hold_start;
    data_mat_t a;
    data_mat_t b;
    acc_mat_t  c;
  } test_entry_t;

  logic          clk;
  logic          reset;
  logic          start;
  data_t [N-1:0] a_data;
  data_t [N-1:0] b_data;
  logic          in_progress;
  logic          c_valid;
  acc_t  [N-1:0] c_data;
  logic          done;

  test_entry_t test_table [NUM_TESTS];
  logic [31:0] lfsr_state;
  int          cycle_count = 0;

  matmul_top #(.N(N)) UUT (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .a_data      (a_data),
    .b_data      (b_data),
    .in_progress (in_progress),
    .c_valid     (c_valid),
    .c_data      (c_data),
    .done        (done)
  );

  bind matmul_top matmul_asserts #(.N(N)) u_asserts (
    .clk         (clk),
    .reset       (reset),
    .in_progress (in_progress),
    .c_valid     (c_valid),
    .done        (done)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus generation and reference model
  ////////////////////////////////////////////////////////////////////////////

  // Right-shifting Galois LFSR with taps at 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic data_t random_element();
    data_t v;
    v = '0;
    for (int n = 0; n < DATA_W; n++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[DATA_W-2:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // C(i,j) is the sum over k of A(i,k) * B(k,j)
  function automatic acc_mat_t reference_product(input data_mat_t a, input data_mat_t b);
    acc_mat_t c;
    c = '0;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        for (int k = 0; k < N; k++) begin
          c[i][j] = c[i][j] + acc_t'(a[i][k]) * acc_t'(b[k][j]);
        end
      end
    end
    return c;
  endfunction

  // Entries 4 and 5 are random, entry 5 holds start high through its operation
  task automatic build_table();
    test_entry_t entry;
    for (int t = 0; t < NUM_TESTS; t++) begin
      entry = '0;
      entry.kind = (t == 4 || t == 5) ? KIND_RANDOM : KIND_FIXED;
      entry.hold_start = (t == 5);
      for (int i = 0; i < N; i++) begin
        for (int k = 0; k < N; k++) begin
          if (entry.kind == KIND_RANDOM) begin
            entry.a[i][k] = random_element();
            entry.b[i][k] = random_element();
          end else begin
            case (t)
              0: begin
                entry.a[i][k] = data_t'(i == k);
                entry.b[i][k] = data_t'(16 * i + k + 1);
              end
              1: begin
                entry.a[i][k] = data_t'(3 * i + 7 * k + 2);
                entry.b[i][k] = data_t'(i == k);
              end
              2: begin
                entry.a[i][k] = data_t'(1);
                entry.b[i][k] = data_t'(1);
              end
              3: begin
                entry.a[i][k] = data_t'(255);
                entry.b[i][k] = data_t'(255);
              end
              default: begin
                entry.a[i][k] = data_t'(i * N + k + 200);
                entry.b[i][k] = data_t'(250 - 9 * i - 5 * k);
              end
            endcase
          end
        end
      end
      entry.c = reference_product(entry.a, entry.b);
      test_table[t] = entry;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_acc(input string name, input acc_t got, input acc_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

  // Between operations all status outputs are low
  task automatic check_state();
    check_bit("in_progress", in_progress, 1'b0);
    check_bit("c_valid", c_valid, 1'b0);
    check_bit("done", done, 1'b0);
  endtask

  // Outputs are sampled 1 ns after the edge, inputs change 2 ns after it
  task automatic run_operation(input int t);
    test_entry_t e;
    int          r;
    e = test_table[t];
    @(posedge clk);
    #1 check_state();
    #1 start = 1'b1;
    for (int c = 0; c <= 4 * N - 2; c++) begin
      @(posedge clk);
      #1 check_bit("in_progress", in_progress, c <= 3 * N - 3);
      if (c >= 3 * N - 2 && c <= 4 * N - 3) begin
        if (c_valid !== 1'b1) begin
          report_failure($sformatf("c_valid was not high in cycle %0d of test %0d", c, t));
        end
        r = c - (3 * N - 2);
        for (int j = 0; j < N; j++) begin
          check_acc($sformatf("c_data[%0d] (row %0d, test %0d)", j, r, t), c_data[j], e.c[r][j]);
        end
      end else begin
        check_bit("c_valid", c_valid, 1'b0);
      end
      if (c == 4 * N - 2) begin
        if (done !== 1'b1) begin
          report_failure($sformatf("done was not raised at the end of test %0d", t));
        end
      end else begin
        check_bit("done", done, 1'b0);
      end
      #1;
      if (!e.hold_start) begin
        start = 1'b0;
      end
      // Outside the load window the inputs are all ones and must not reach the grid
      for (int i = 0; i < N; i++) begin
        if (c < N) begin
          a_data[i] = e.a[i][c];
          b_data[i] = e.b[c][i];
        end else begin
          a_data[i] = '1;
          b_data[i] = '1;
        end
      end
    end
    // A start level that never falls must not begin another operation
    if (e.hold_start) begin
      repeat (3) begin
        @(posedge clk);
        #1 check_state();
      end
      #1 start = 1'b0;
    end
  endtask

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    start = 1'b0;
    a_data = '0;
    b_data = '0;
    lfsr_state = 32'h6bd8;
    build_table();
    repeat (10) begin
      @(posedge clk);
      #1 check_state();
    end
    #1 reset = 1'b0;
    repeat (3) begin
      @(posedge clk);
      #1 check_state();
    end
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_operation(t);
    end
    $display("** PASS **");
    $finish;
  end

endmodule

//--- sources.f
verilog/matmul_cfg_pkg.sv
verilog/matmul_ctrl_pkg.sv
verilog/matmul_ctrl_if.sv
verilog/matmul_ctrl.sv
verilog/phase_timer.sv
verilog/operand_skew.sv
verilog/pe_array.sv
verilog/result_drain.sv
verilog/matmul_top.sv
verif/matmul_asserts.sv
verif/tb_matmul.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module tb_matmul -Mdir obj_dir
	./obj_dir/Vtb_matmul

clean:
	rm -rf obj_dir
